/* compile.f */
riscv_pkg.sv
control_unit.sv
imm_gen.sv
register_bank.sv
alu.sv
program_counter.sv
data_memory.sv
microprocessor.sv
tb_microprocessor.sv

/* Makefile */
# sources come straight from the file list
SRCS := $(shell cat compile.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vtb_microprocessor: $(SRCS) compile.f
	verilator --binary --timing --assert --top-module tb_microprocessor -f compile.f

# pass only if the log holds the pass line
run: obj_dir/Vtb_microprocessor
	./obj_dir/Vtb_microprocessor | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_microprocessor.sv */
`timescale 1ns/1ns

module tb_microprocessor;

	localparam int max_cycles = 1000;

	// what the dut should show for one instruction
	typedef struct packed {
		logic [31:0]        alu_result;
		logic               memread;
		logic               memwrite;
		logic               memtoreg;
		riscv_pkg::retire_t retire;
		logic [31:0]        next_pc;
		logic [5:0]         mem_idx;
		logic [31:0]        store_data;
	} expect_t;

	logic               clk;
	logic               arst_n;
	logic [31:0]        instruction;
	logic [31:0]        pc_out;
	logic [31:0]        alu_result;
	logic               memread;
	logic               memwrite;
	logic               memtoreg;
	riscv_pkg::retire_t retire;

	// model state, owned by the compare process
	logic [31:0] mregs [32];
	logic [31:0] mmem [64];
	logic [31:0] mpc;
	expect_t     cur;

	integer      seed = 78455;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          failed_tests = 0;
	int          err_start = 0;
	int          cycles = 0;
	string       test_name;
	logic [31:0] r;
	logic [31:0] r2;

	microprocessor #(
		.reset_vector(32'd0),
		.dmem_depth  (64)
	) UUT (
		.clk        (clk),
		.arst_n     (arst_n),
		.instruction(instruction),
		.pc_out     (pc_out),
		.alu_result (alu_result),
		.memread    (memread),
		.memwrite   (memwrite),
		.memtoreg   (memtoreg),
		.retire     (retire)
	);

	// instruction encoders, straight from the rv32i formats
	function automatic logic [31:0] add_word(input logic [4:0] rd, rs1, rs2);
		return {7'b0000000, rs2, rs1, 3'b000, rd, riscv_pkg::opcode_r_type};
	endfunction

	function automatic logic [31:0] sub_word(input logic [4:0] rd, rs1, rs2);
		return {riscv_pkg::funct7_sub, rs2, rs1, 3'b000, rd, riscv_pkg::opcode_r_type};
	endfunction

	function automatic logic [31:0] addi_word(input logic [4:0] rd, rs1, input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, riscv_pkg::opcode_i_type};
	endfunction

	function automatic logic [31:0] lw_word(input logic [4:0] rd, rs1, input logic [11:0] imm);
		return {imm, rs1, 3'b010, rd, riscv_pkg::opcode_load};
	endfunction

	function automatic logic [31:0] sw_word(input logic [4:0] rs2, rs1, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], riscv_pkg::opcode_store};
	endfunction

	function automatic logic [31:0] beq_word(input logic [4:0] rs1, rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11],
		        riscv_pkg::opcode_b_type};
	endfunction

	function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, riscv_pkg::opcode_j_type};
	endfunction

	// reference model, next state follows from the returned record
	function automatic expect_t predict(input logic [31:0] ins);
		expect_t     e;
		logic [4:0]  rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] pc4;
		logic        wr;
		logic        link;
		rd   = ins[11:7];
		a    = mregs[ins[19:15]];
		b    = mregs[ins[24:20]];
		pc4  = mpc + 32'd4;
		e    = '0;
		wr   = 1'b0;
		link = 1'b0;
		// undecoded words still add rs1 and rs2
		e.alu_result = a + b;
		e.next_pc    = pc4;
		case (ins[6:0])
			riscv_pkg::opcode_r_type: begin
				if (ins[14:12] == 3'b000 && ins[31:25] == 7'b0000000) begin
					wr = 1'b1;
				end else if (ins[14:12] == 3'b000 && ins[31:25] == riscv_pkg::funct7_sub) begin
					e.alu_result = a - b;
					wr           = 1'b1;
				end
			end
			riscv_pkg::opcode_i_type: begin
				if (ins[14:12] == 3'b000) begin
					e.alu_result = a + {{20{ins[31]}}, ins[31:20]};
					wr           = 1'b1;
				end
			end
			riscv_pkg::opcode_load: begin
				e.alu_result = a + {{20{ins[31]}}, ins[31:20]};
				e.memread    = 1'b1;
				e.memtoreg   = 1'b1;
				wr           = 1'b1;
			end
			riscv_pkg::opcode_store: begin
				e.alu_result = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
				e.memwrite   = 1'b1;
			end
			riscv_pkg::opcode_b_type: begin
				e.alu_result = a - b;
				if (a == b) begin
					e.next_pc = mpc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
				end
			end
			riscv_pkg::opcode_j_type: begin
				wr        = 1'b1;
				link      = 1'b1;
				e.next_pc = mpc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			end
			default: begin
			end
		endcase
		// 64 words, word index from the bits above bit 1
		e.mem_idx        = e.alu_result[7:2];
		e.store_data     = b;
		e.retire.wb_en   = wr && (rd != 5'd0);
		e.retire.wb_rd   = rd;
		e.retire.wb_data = link ? pc4 : (e.memtoreg ? mmem[e.mem_idx] : e.alu_result);
		return e;
	endfunction

	task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
		$display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
		errors++;
	endtask

	// new instruction shortly after the edge
	task automatic issue(input logic [31:0] ins);
		@(posedge clk);
		#1;
		instruction = ins;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		err_start = errors;
	endtask

	// a trailing nop lets the last pc update get checked
	task automatic finish_test();
		issue(32'd0);
		@(negedge clk);
		#1;
		tests++;
		if (errors == err_start) begin
			$display("test %s: ok", test_name);
		end else begin
			failed_tests++;
			$display("test %s: FAILED with %0d errors", test_name, errors - err_start);
		end
	endtask

	// mixed stream, sources mostly x0..x7 so beq hits equal pairs
	task automatic pick_instruction(output logic [31:0] ins);
		logic [31:0] a;
		logic [31:0] b;
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [6:0]  unused_op;
		a  = $random(seed);
		b  = $random(seed);
		ra = {2'b00, a[2:0]};
		rb = {2'b00, a[5:3]};
		case (b[5:4])
			2'd0:    unused_op = 7'b0110111;
			2'd1:    unused_op = 7'b0010111;
			2'd2:    unused_op = 7'b1100111;
			default: unused_op = 7'b1110011;
		endcase
		case (b[2:0])
			3'd0: ins = add_word(a[10:6], ra, rb);
			3'd1: ins = sub_word(a[10:6], ra, rb);
			3'd2: ins = addi_word(a[10:6], ra, a[31:20]);
			3'd3: ins = lw_word(a[10:6], ra, a[31:20]);
			3'd4: ins = sw_word(rb, ra, a[31:20]);
			3'd5: ins = beq_word(ra, rb, {a[31:20], 1'b0});
			3'd6: ins = jal_word(a[10:6], {a[31:12], 1'b0});
			default: begin
				// unused opcode, or an r type funct3 other than add
				if (b[3]) begin
					ins = {a[31:7], unused_op};
				end else begin
					ins = {7'b0000000, rb, ra, 3'b100, a[10:6], riscv_pkg::opcode_r_type};
				end
			end
		endcase
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// compare process, samples mid cycle then advances the model
	initial begin
		for (int i = 0; i < 32; i++) begin
			mregs[i] = '0;
		end
		for (int i = 0; i < 64; i++) begin
			mmem[i] = '0;
		end
		mpc = 32'd0;
		forever begin
			@(negedge clk);
			if (arst_n) begin
				cur = predict(instruction);
				assert (pc_out == mpc)
					else mismatch("pc_out", pc_out, mpc);
				assert (alu_result == cur.alu_result)
					else mismatch("alu_result", alu_result, cur.alu_result);
				assert (memread == cur.memread)
					else mismatch("memread", 32'(memread), 32'(cur.memread));
				assert (memwrite == cur.memwrite)
					else mismatch("memwrite", 32'(memwrite), 32'(cur.memwrite));
				assert (memtoreg == cur.memtoreg)
					else mismatch("memtoreg", 32'(memtoreg), 32'(cur.memtoreg));
				assert (retire.wb_en == cur.retire.wb_en)
					else mismatch("wb_en", 32'(retire.wb_en), 32'(cur.retire.wb_en));
				assert (retire.wb_rd == cur.retire.wb_rd)
					else mismatch("wb_rd", 32'(retire.wb_rd), 32'(cur.retire.wb_rd));
				assert (retire.wb_data == cur.retire.wb_data)
					else mismatch("wb_data", retire.wb_data, cur.retire.wb_data);
				checks += 8;
				// same commit the dut does on the coming edge
				if (cur.retire.wb_en) begin
					mregs[cur.retire.wb_rd] = cur.retire.wb_data;
				end
				if (cur.memwrite) begin
					mmem[cur.mem_idx] = cur.store_data;
				end
				mpc = cur.next_pc;
			end
		end
	end

	// watchdog
	initial begin
		while (cycles < max_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("run timed out after %0d cycles before the tests finished", cycles);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		instruction = 32'd0;
		arst_n      = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// pc at zero, all levels low with a zero word
		start_test("reset");
		finish_test();

		start_test("arith");
		for (int i = 0; i < 12; i++) begin
			r = $random(seed);
			issue(addi_word(r[4:0], r[9:5], r[31:20]));
		end
		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			if (r[15]) begin
				issue(sub_word(r[4:0], r[9:5], r[14:10]));
			end else begin
				issue(add_word(r[4:0], r[9:5], r[14:10]));
			end
		end
		// x0 write hidden, x0 read back as zero
		issue(addi_word(5'd0, 5'd0, 12'h5a5));
		issue(add_word(5'd7, 5'd0, 5'd0));
		finish_test();

		start_test("beq");
		issue(addi_word(5'd10, 5'd0, 12'd77));
		issue(addi_word(5'd11, 5'd0, 12'd77));
		issue(addi_word(5'd12, 5'd0, 12'd78));
		issue(beq_word(5'd10, 5'd11, 13'd16));
		issue(beq_word(5'd10, 5'd12, 13'd16));
		issue(beq_word(5'd10, 5'd11, -13'sd24));
		issue(beq_word(5'd12, 5'd10, -13'sd8));
		for (int i = 0; i < 6; i++) begin
			r = $random(seed);
			issue(beq_word(5'd10, r[13] ? 5'd11 : 5'd12, {r[12:1], 1'b0}));
		end
		finish_test();

		start_test("jal");
		issue(jal_word(5'd1, 21'd64));
		issue(jal_word(5'd5, -21'sd32));
		issue(jal_word(5'd0, 21'd12));
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			issue(jal_word(r[4:0], {r[20:1], 1'b0}));
		end
		finish_test();

		start_test("load_store");
		for (int i = 0; i < 8; i++) begin
			r  = $random(seed);
			r2 = $random(seed);
			// aligned address under 2 KiB, beyond 64 words it wraps
			issue(addi_word(5'd1, 5'd0, {1'b0, r[10:2], 2'b00}));
			issue(addi_word(5'd2, 5'd0, r2[11:0]));
			issue(sw_word(5'd2, 5'd1, 12'd0));
			issue(lw_word(5'd3, 5'd1, 12'd0));
			// 256 bytes up is the same word
			issue(lw_word(5'd4, 5'd1, 12'd256));
		end
		finish_test();

		start_test("mixed");
		for (int i = 1; i < 8; i++) begin
			r = $random(seed);
			issue(addi_word(5'(i), 5'd0, r[11:0]));
		end
		for (int i = 0; i < 200; i++) begin
			pick_instruction(r);
			issue(r);
		end
		finish_test();

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
		         tests, failed_tests, checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* microprocessor.sv */
`timescale 1ns/1ns

module microprocessor #(
	parameter logic [riscv_pkg::xlen-1:0] reset_vector = '0,
	parameter int                         dmem_depth   = 64
) (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic [riscv_pkg::xlen-1:0] instruction,
	output logic [riscv_pkg::xlen-1:0] pc_out,
	output logic [riscv_pkg::xlen-1:0] alu_result,
	output logic                       memread,
	output logic                       memwrite,
	output logic                       memtoreg,
	output riscv_pkg::retire_t         retire
);

	riscv_pkg::ctrl_t           ctrl;
	logic [riscv_pkg::xlen-1:0] imm;

	// register fields, same position in every format
	logic [4:0]                 rs1;
	logic [4:0]                 rs2;
	logic [4:0]                 rd;

	logic [riscv_pkg::xlen-1:0] rs1_data;
	logic [riscv_pkg::xlen-1:0] rs2_data;
	logic [riscv_pkg::xlen-1:0] alu_b;
	logic                       alu_equal;
	logic [riscv_pkg::xlen-1:0] pc_plus4;
	logic [riscv_pkg::xlen-1:0] mem_rd_data;
	logic [riscv_pkg::xlen-1:0] wb_data;

	assign rs1 = instruction[19:15];
	assign rs2 = instruction[24:20];
	assign rd  = instruction[11:7];

	// decode
	control_unit control_i (
		.instruction(instruction),
		.ctrl       (ctrl)
	);

	imm_gen imm_i (
		.instruction(instruction),
		.imm        (imm)
	);

	// x0 filtering done inside the bank
	register_bank prf_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.rs1     (rs1),
		.rs2     (rs2),
		.rd      (rd),
		.wr_en   (ctrl.reg_write),
		.wr_data (wb_data),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data)
	);

	// immediate for addi, lw, sw
	assign alu_b = ctrl.alu_src_imm ? imm : rs2_data;

	alu alu_i (
		.op_a  (rs1_data),
		.op_b  (alu_b),
		.op    (ctrl.alu_op),
		.result(alu_result),
		.equal (alu_equal)
	);

	program_counter #(
		.reset_vector(reset_vector)
	) pc_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.branch  (ctrl.branch),
		.jump    (ctrl.jump),
		.equal   (alu_equal),
		.imm     (imm),
		.pc      (pc_out),
		.pc_plus4(pc_plus4)
	);

	// alu result is the byte address
	data_memory #(
		.depth(dmem_depth)
	) dmem_i (
		.clk    (clk),
		.arst_n (arst_n),
		.addr   (alu_result),
		.wr_en  (ctrl.mem_write),
		.wr_data(rs2_data),
		.rd_data(mem_rd_data)
	);

	// write-back select, link wins over memory
	assign wb_data = ctrl.link       ? pc_plus4    :
	                 ctrl.mem_to_reg ? mem_rd_data : alu_result;

	// outside control levels
	assign memread  = ctrl.mem_read;
	assign memwrite = ctrl.mem_write;
	assign memtoreg = ctrl.mem_to_reg;

	// what the next edge commits, x0 writes hidden
	assign retire.wb_en   = ctrl.reg_write && (rd != 5'd0);
	assign retire.wb_rd   = rd;
	assign retire.wb_data = wb_data;

endmodule

/* data_memory.sv */
`timescale 1ns/1ns

module data_memory #(
	// words, power of two
	parameter int depth = 64
) (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic [riscv_pkg::xlen-1:0] addr,
	input  logic                       wr_en,
	input  logic [riscv_pkg::xlen-1:0] wr_data,
	output logic [riscv_pkg::xlen-1:0] rd_data
);

	localparam int idx_w = $clog2(depth);

	logic [riscv_pkg::xlen-1:0] mem [depth];
	logic [idx_w-1:0]           idx;

	// byte address to word index
	// bits [1:0] ignored, upper bits wrap modulo depth
	assign idx = addr[idx_w+1:2];

	// store on the edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < depth; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_en) begin
			mem[idx] <= wr_data;
		end
	end

	// load data ready in the same cycle
	assign rd_data = mem[idx];

endmodule

/* program_counter.sv */
`timescale 1ns/1ns

module program_counter #(
	parameter logic [riscv_pkg::xlen-1:0] reset_vector = '0
) (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       branch,
	input  logic                       jump,
	input  logic                       equal,
	input  logic [riscv_pkg::xlen-1:0] imm,
	output logic [riscv_pkg::xlen-1:0] pc,
	output logic [riscv_pkg::xlen-1:0] pc_plus4
);

	logic [riscv_pkg::xlen-1:0] pc_target;
	logic [riscv_pkg::xlen-1:0] pc_next;
	logic                       take;

	// sequential path, also the jal link value
	assign pc_plus4 = pc + riscv_pkg::xlen'(4);

	// pc relative target for beq and jal
	assign pc_target = pc + imm;

	// jal always, beq only when operands match
	assign take = jump | (branch & equal);

	assign pc_next = take ? pc_target : pc_plus4;

	// one instruction per cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= reset_vector;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

/* alu.sv */
`timescale 1ns/1ns

module alu (
	input  logic [riscv_pkg::xlen-1:0] op_a,
	input  logic [riscv_pkg::xlen-1:0] op_b,
	input  riscv_pkg::alu_op_e         op,
	output logic [riscv_pkg::xlen-1:0] result,
	output logic                       equal
);

	logic [riscv_pkg::xlen-1:0] sum;
	logic [riscv_pkg::xlen-1:0] diff;

	// both computed, op only picks
	// carry out discarded, wraps like rv32i
	assign sum  = op_a + op_b;
	assign diff = op_a - op_b;

	always_comb begin
		case (op)
			riscv_pkg::alu_sub: begin
				result = diff;
			end
			default: begin
				result = sum;
			end
		endcase
	end

	// beq compare
	// independent of op so branch decode stays simple
	assign equal = (op_a == op_b);

endmodule

/* register_bank.sv */
`timescale 1ns/1ns

module register_bank (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic [4:0]                 rs1,
	input  logic [4:0]                 rs2,
	input  logic [4:0]                 rd,
	input  logic                       wr_en,
	input  logic [riscv_pkg::xlen-1:0] wr_data,
	output logic [riscv_pkg::xlen-1:0] rs1_data,
	output logic [riscv_pkg::xlen-1:0] rs2_data
);

	// x1 to x31, x0 has no storage
	logic [riscv_pkg::xlen-1:0] prf [1:31];

	// write port, single edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++) begin
				prf[i] <= '0;
			end
		end else begin
			// writes to x0 dropped here only
			if (wr_en && rd != 5'd0) begin
				prf[rd] <= wr_data;
			end
		end
	end

	// combinational read ports
	always_comb begin
		if (rs1 == 5'd0) begin
			rs1_data = '0;
		end else begin
			rs1_data = prf[rs1];
		end
	end

	always_comb begin
		if (rs2 == 5'd0) begin
			rs2_data = '0;
		end else begin
			rs2_data = prf[rs2];
		end
	end

endmodule

/* imm_gen.sv */
`timescale 1ns/1ns

module imm_gen (
	input  logic [riscv_pkg::xlen-1:0] instruction,
	output logic [riscv_pkg::xlen-1:0] imm
);

	logic [6:0] opcode;
	// sign bit sits at bit 31 for every format
	logic       sign;

	assign opcode = instruction[6:0];
	assign sign   = instruction[31];

	always_comb begin
		case (opcode)
			// I format, addi and lw
			riscv_pkg::opcode_i_type,
			riscv_pkg::opcode_load: begin
				imm = {{(riscv_pkg::xlen-12){sign}}, instruction[31:20]};
			end
			// S format, split around rd position
			riscv_pkg::opcode_store: begin
				imm = {{(riscv_pkg::xlen-12){sign}}, instruction[31:25],
				       instruction[11:7]};
			end
			// B format, imm[12|10:5] ... imm[4:1|11], bit 0 implied
			riscv_pkg::opcode_b_type: begin
				imm = {{(riscv_pkg::xlen-13){sign}}, instruction[31], instruction[7],
				       instruction[30:25], instruction[11:8], 1'b0};
			end
			// J format, imm[20|10:1|11|19:12], bit 0 implied
			riscv_pkg::opcode_j_type: begin
				imm = {{(riscv_pkg::xlen-21){sign}}, instruction[31],
				       instruction[19:12], instruction[20], instruction[30:21], 1'b0};
			end
			// R type and unused opcodes carry no immediate
			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

/* control_unit.sv */
`timescale 1ns/1ns

module control_unit (
	input  logic [riscv_pkg::xlen-1:0] instruction,
	output riscv_pkg::ctrl_t           ctrl
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	// fixed field positions, common to all formats
	assign opcode = instruction[6:0];
	assign funct3 = instruction[14:12];
	assign funct7 = instruction[31:25];

	always_comb begin
		// anything not matched below stays a no-operation
		ctrl = '0;
		case (opcode)
			riscv_pkg::opcode_r_type: begin
				// only add and sub are decoded
				if (funct3 == 3'b000 &&
				    (funct7 == 7'b0000000 || funct7 == riscv_pkg::funct7_sub)) begin
					ctrl.reg_write = 1'b1;
					ctrl.alu_op    = (funct7 == riscv_pkg::funct7_sub) ?
					                 riscv_pkg::alu_sub : riscv_pkg::alu_add;
				end
			end
			riscv_pkg::opcode_i_type: begin
				// addi only
				if (funct3 == 3'b000) begin
					ctrl.reg_write   = 1'b1;
					ctrl.alu_src_imm = 1'b1;
				end
			end
			riscv_pkg::opcode_load: begin
				// address is rs1 + imm, data goes to rd
				ctrl.reg_write   = 1'b1;
				ctrl.mem_read    = 1'b1;
				ctrl.mem_to_reg  = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			riscv_pkg::opcode_store: begin
				// address is rs1 + imm, rs2 is the store data
				ctrl.mem_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			riscv_pkg::opcode_b_type: begin
				// compare rs1 with rs2, taken decision in the pc
				ctrl.branch = 1'b1;
				ctrl.alu_op = riscv_pkg::alu_sub;
			end
			riscv_pkg::opcode_j_type: begin
				// rd gets the return address
				ctrl.reg_write = 1'b1;
				ctrl.jump      = 1'b1;
				ctrl.link      = 1'b1;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

/* riscv_pkg.sv */
package riscv_pkg;

	// register and data width
	localparam int xlen = 32;

	// major opcodes, instruction bits [6:0]
	// add, sub
	localparam logic [6:0] opcode_r_type = 7'b0110011;
	// addi
	localparam logic [6:0] opcode_i_type = 7'b0010011;
	// lw
	localparam logic [6:0] opcode_load   = 7'b0000011;
	// sw
	localparam logic [6:0] opcode_store  = 7'b0100011;
	// beq
	localparam logic [6:0] opcode_b_type = 7'b1100011;
	// jal
	localparam logic [6:0] opcode_j_type = 7'b1101111;

	// funct7 value turning an R-type add into sub
	localparam logic [6:0] funct7_sub = 7'b0100000;

	// alu operation select
	typedef enum logic {
		alu_add = 1'b0,
		alu_sub = 1'b1
	} alu_op_e;

	// decoded control word, all zero means no-operation
	typedef struct packed {
		// instruction writes rd
		logic    reg_write;
		// load
		logic    mem_read;
		// store
		logic    mem_write;
		// write-back taken from memory
		logic    mem_to_reg;
		// second alu operand is the immediate
		logic    alu_src_imm;
		alu_op_e alu_op;
		// beq
		logic    branch;
		// jal
		logic    jump;
		// write-back is pc + 4
		logic    link;
	} ctrl_t;

	// register write committed on the next clock edge
	typedef struct packed {
		// set only for a real write, never for x0
		logic            wb_en;
		logic [4:0]      wb_rd;
		logic [xlen-1:0] wb_data;
	} retire_t;

endpackage
